//--- logic/rvlite_pkg.sv
// assumes RV32 word addressing with aligned word accesses and no compressed instructions
package rvlite_pkg;

	localparam int xlen       = 32;
	localparam int reg_addr_w = 5;

	// major opcodes of the supported instructions
	localparam logic [6:0] opc_op_imm = 7'b001_0011;
	localparam logic [6:0] opc_auipc  = 7'b001_0111;
	localparam logic [6:0] opc_lui    = 7'b011_0111;
	localparam logic [6:0] opc_jal    = 7'b110_1111;
	localparam logic [6:0] opc_jalr   = 7'b110_0111;
	localparam logic [6:0] opc_store  = 7'b010_0011;
	localparam logic [6:0] opc_load   = 7'b000_0011;

	localparam logic [xlen-1:0] inst_ebreak_word = 32'h0010_0073;
	localparam logic [xlen-1:0] reset_pc         = 32'h0000_0000;

	// apb master to slave
	typedef struct packed {
		logic [xlen-1:0] paddr;
		logic [xlen-1:0] pwdata;
		logic            pwrite;
		logic            psel;
		logic            penable;
	} apb_req_t;

	// apb slave to master
	typedef struct packed {
		logic [xlen-1:0] prdata;
		logic            pready;
		logic            pslverr;
	} apb_rsp_t;

	typedef struct packed {
		logic [11:0]           imm;
		logic [reg_addr_w-1:0] rs1;
		logic [2:0]            funct3;
		logic [reg_addr_w-1:0] rd;
		logic [6:0]            opcode;
	} inst_i_t;

	typedef struct packed {
		logic [6:0]            imm_hi;
		logic [reg_addr_w-1:0] rs2;
		logic [reg_addr_w-1:0] rs1;
		logic [2:0]            funct3;
		logic [4:0]            imm_lo;
		logic [6:0]            opcode;
	} inst_s_t;

	// same 32 bits seen as i-format, s-format or raw
	typedef union packed {
		inst_i_t         i;
		inst_s_t         s;
		logic [xlen-1:0] raw;
	} inst_word_u;

	typedef struct packed {
		logic [xlen-1:0]       src1;
		logic [xlen-1:0]       src2;
		logic [xlen-1:0]       store_data;
		logic [xlen-1:0]       pc;
		logic [reg_addr_w-1:0] rd;
		logic                  is_jump;
		logic                  is_store;
		logic                  is_load;
		logic                  writes_rd;
		logic                  is_ebreak;
	} decode_t;

	typedef struct packed {
		logic                  valid;
		logic [xlen-1:0]       pc;
		logic [reg_addr_w-1:0] rd;
		logic [xlen-1:0]       wdata;
		logic                  wen;
	} retire_t;

endpackage

//--- logic/rvlite_regfile.sv
// reads are combinational and x0 always reads zero with no reset on the array
module rvlite_regfile (
	input  logic                              clk,
	input  logic [rvlite_pkg::reg_addr_w-1:0] raddr1,
	input  logic [rvlite_pkg::reg_addr_w-1:0] raddr2,
	input  logic [rvlite_pkg::reg_addr_w-1:0] waddr,
	input  logic [rvlite_pkg::xlen-1:0]       wdata,
	input  logic                              wen,
	output logic [rvlite_pkg::xlen-1:0]       rdata1,
	output logic [rvlite_pkg::xlen-1:0]       rdata2
);

	logic [rvlite_pkg::xlen-1:0] regs [32];

	// entry 0 is never written
	always_ff @(posedge clk) begin
		if (wen && waddr != '0)
			regs[waddr] <= wdata;
	end

	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- logic/rvlite_ifu.sv
// one fetch in flight at a time and a fetch error is delivered as an ebreak word so the core halts
module rvlite_ifu (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        commit,
	input  logic [rvlite_pkg::xlen-1:0] next_pc,
	input  logic                        halted,
	input  logic                        inst_ready,
	input  rvlite_pkg::apb_rsp_t        bus_rsp,
	output rvlite_pkg::apb_req_t        bus_req,
	output logic                        inst_valid,
	output rvlite_pkg::inst_word_u      inst,
	output logic [rvlite_pkg::xlen-1:0] inst_pc
);

	typedef enum logic [1:0] {
		f_idle,
		f_setup,
		f_access
	} fetch_state_t;

	fetch_state_t                state;
	logic [rvlite_pkg::xlen-1:0] pc_q;
	logic [rvlite_pkg::xlen-1:0] pc_d;
	logic [rvlite_pkg::xlen-1:0] fetch_addr;
	logic                        busy;
	logic                        buf_valid;
	logic                        buf_valid_d;
	logic [rvlite_pkg::xlen-1:0] buf_pc;
	rvlite_pkg::inst_word_u      buf_word;
	logic                        xfer;
	logic                        fetch_hit;

	assign xfer       = inst_valid && inst_ready;
	assign inst_valid = buf_valid && !busy;
	assign inst       = buf_word;
	assign inst_pc    = buf_pc;

	// next wanted pc, guessed as pc+4 until the execute unit commits
	always_comb begin
		if (commit)
			pc_d = next_pc;
		else if (xfer)
			pc_d = buf_pc + 32'd4;
		else
			pc_d = pc_q;
	end

	// a returning word is kept only if it is still the one wanted
	assign fetch_hit = (state == f_access) && bus_rsp.pready && (fetch_addr == pc_d);

	always_comb begin
		buf_valid_d = buf_valid;
		if (xfer || (commit && buf_pc != next_pc))
			buf_valid_d = 1'b0;
		if (fetch_hit)
			buf_valid_d = 1'b1;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= f_idle;
			pc_q      <= rvlite_pkg::reset_pc;
			busy      <= 1'b0;
			buf_valid <= 1'b0;
		end else begin
			pc_q      <= pc_d;
			buf_valid <= buf_valid_d;
			if (xfer)
				busy <= 1'b1;
			else if (commit)
				busy <= 1'b0;
			case (state)
				f_idle:   if (!halted && !buf_valid_d) state <= f_setup;
				f_setup:  state <= f_access;
				f_access: if (bus_rsp.pready) state <= f_idle;
				default:  state <= f_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == f_idle)
			fetch_addr <= pc_d;
		if (fetch_hit) begin
			buf_pc       <= fetch_addr;
			buf_word.raw <= bus_rsp.pslverr ? rvlite_pkg::inst_ebreak_word : bus_rsp.prdata;
		end
	end

	always_comb begin
		bus_req         = '0;
		bus_req.paddr   = fetch_addr;
		bus_req.psel    = (state != f_idle);
		bus_req.penable = (state == f_access);
	end

endmodule

//--- logic/rvlite_idu.sv
// decodes addi auipc lui jal jalr sw lw and ebreak only and every other word becomes a no-op
module rvlite_idu (
	input  logic                              clk,
	input  rvlite_pkg::inst_word_u            inst,
	input  logic [rvlite_pkg::xlen-1:0]       inst_pc,
	input  logic [rvlite_pkg::reg_addr_w-1:0] wb_addr,
	input  logic [rvlite_pkg::xlen-1:0]       wb_data,
	input  logic                              wb_en,
	output rvlite_pkg::decode_t               dec
);

	logic [6:0]                  opcode;
	logic [2:0]                  funct3;
	logic                        inst_addi;
	logic                        inst_auipc;
	logic                        inst_lui;
	logic                        inst_jal;
	logic                        inst_jalr;
	logic                        inst_sw;
	logic                        inst_lw;
	logic                        inst_ebreak;
	logic [rvlite_pkg::xlen-1:0] imm_i;
	logic [rvlite_pkg::xlen-1:0] imm_s;
	logic [rvlite_pkg::xlen-1:0] imm_u;
	logic [rvlite_pkg::xlen-1:0] imm_j;
	logic [rvlite_pkg::xlen-1:0] imm;
	logic [rvlite_pkg::xlen-1:0] rs1_data;
	logic [rvlite_pkg::xlen-1:0] rs2_data;

	// opcode and funct3 sit at the same place in both formats
	assign opcode = inst.i.opcode;
	assign funct3 = inst.i.funct3;

	assign inst_addi   = (opcode == rvlite_pkg::opc_op_imm) && (funct3 == 3'b000);
	assign inst_auipc  = (opcode == rvlite_pkg::opc_auipc);
	assign inst_lui    = (opcode == rvlite_pkg::opc_lui);
	assign inst_jal    = (opcode == rvlite_pkg::opc_jal);
	assign inst_jalr   = (opcode == rvlite_pkg::opc_jalr) && (funct3 == 3'b000);
	assign inst_sw     = (opcode == rvlite_pkg::opc_store) && (funct3 == 3'b010);
	assign inst_lw     = (opcode == rvlite_pkg::opc_load) && (funct3 == 3'b010);
	assign inst_ebreak = (inst.raw == rvlite_pkg::inst_ebreak_word);

	// immediates
	assign imm_i = {{20{inst.i.imm[11]}}, inst.i.imm};
	assign imm_s = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
	assign imm_u = {inst.raw[31:12], 12'b0};
	assign imm_j = {{12{inst.raw[31]}}, inst.raw[19:12], inst.raw[20], inst.raw[30:21], 1'b0};

	assign imm = ({32{inst_addi | inst_jalr | inst_lw}} & imm_i) |
	             ({32{inst_sw}} & imm_s) |
	             ({32{inst_auipc | inst_lui}} & imm_u) |
	             ({32{inst_jal}} & imm_j);

	rvlite_regfile rvlite_regfile_i (
		.clk    (clk),
		.raddr1 (inst.i.rs1),
		.raddr2 (inst.s.rs2),
		.waddr  (wb_addr),
		.wdata  (wb_data),
		.wen    (wb_en),
		.rdata1 (rs1_data),
		.rdata2 (rs2_data)
	);

	always_comb begin
		dec = '0;
		// lui adds its immediate to zero
		if (inst_jal || inst_auipc)
			dec.src1 = inst_pc;
		else if (inst_lui)
			dec.src1 = '0;
		else
			dec.src1 = rs1_data;
		dec.src2       = imm;
		dec.store_data = rs2_data;
		dec.pc         = inst_pc;
		dec.rd         = inst.i.rd;
		dec.is_jump    = inst_jal || inst_jalr;
		dec.is_store   = inst_sw;
		dec.is_load    = inst_lw;
		dec.writes_rd  = inst_addi || inst_auipc || inst_lui || inst_jal || inst_jalr || inst_lw;
		dec.is_ebreak  = inst_ebreak;
	end

endmodule

//--- logic/rvlite_exu.sv
// one instruction at a time and the core stops for good on ebreak or a data bus error
module rvlite_exu (
	input  logic                              clk,
	input  logic                              rst,
	input  rvlite_pkg::decode_t               dec,
	input  logic                              inst_valid,
	input  logic                              mem_done,
	input  logic [rvlite_pkg::xlen-1:0]       mem_rdata,
	input  logic                              mem_err,
	output logic                              inst_ready,
	output logic                              mem_req,
	output logic                              mem_write,
	output logic [rvlite_pkg::xlen-1:0]       mem_addr,
	output logic [rvlite_pkg::xlen-1:0]       mem_wdata,
	output logic [rvlite_pkg::reg_addr_w-1:0] wb_addr,
	output logic [rvlite_pkg::xlen-1:0]       wb_data,
	output logic                              wb_en,
	output logic                              commit,
	output logic [rvlite_pkg::xlen-1:0]       next_pc,
	output logic                              halted,
	output rvlite_pkg::retire_t               retire
);

	typedef enum logic [2:0] {
		ex_idle,
		ex_exec,
		ex_mem,
		ex_done,
		ex_stop
	} ex_state_t;

	ex_state_t                   state;
	rvlite_pkg::decode_t         dec_q;
	logic [rvlite_pkg::xlen-1:0] sum;
	logic [rvlite_pkg::xlen-1:0] pc_plus4;
	logic [rvlite_pkg::xlen-1:0] load_q;
	logic [rvlite_pkg::xlen-1:0] result;

	// every supported instruction is an add
	assign sum      = dec_q.src1 + dec_q.src2;
	assign pc_plus4 = dec_q.pc + 32'd4;

	assign inst_ready = (state == ex_idle);
	assign mem_req    = (state == ex_mem);
	assign mem_write  = dec_q.is_store;
	assign mem_addr   = sum;
	assign mem_wdata  = dec_q.store_data;
	assign commit     = (state == ex_exec) || (state == ex_done);

	// jal targets are even already so clearing bit 0 only matters for jalr
	always_comb begin
		if (dec_q.is_jump) begin
			result  = pc_plus4;
			next_pc = {sum[rvlite_pkg::xlen-1:1], 1'b0};
		end else begin
			result  = dec_q.is_load ? load_q : sum;
			next_pc = pc_plus4;
		end
	end

	assign wb_addr = dec_q.rd;
	assign wb_data = (dec_q.rd == '0) ? '0 : result;
	assign wb_en   = commit && dec_q.writes_rd;

	always_ff @(posedge clk) begin
		if (rst) begin
			state  <= ex_idle;
			halted <= 1'b0;
			retire <= '0;
		end else begin
			case (state)
				ex_idle: if (inst_valid) state <= (dec.is_load || dec.is_store) ? ex_mem : ex_exec;
				ex_exec: state <= dec_q.is_ebreak ? ex_stop : ex_idle;
				ex_mem:  if (mem_done) state <= mem_err ? ex_stop : ex_done;
				ex_done: state <= ex_idle;
				default: state <= ex_stop;
			endcase
			if ((mem_done && mem_err) || state == ex_stop)
				halted <= 1'b1;
			retire.valid <= commit;
			retire.pc    <= dec_q.pc;
			retire.rd    <= dec_q.rd;
			retire.wdata <= wb_data;
			retire.wen   <= wb_en;
		end
	end

	always_ff @(posedge clk) begin
		if (inst_valid && inst_ready)
			dec_q <= dec;
		if (mem_done)
			load_q <= mem_rdata;
	end

endmodule

//--- logic/rvlite_lsu.sv
// one word transfer per request and mem_done follows pready in the same cycle
module rvlite_lsu (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        mem_req,
	input  logic                        mem_write,
	input  logic [rvlite_pkg::xlen-1:0] mem_addr,
	input  logic [rvlite_pkg::xlen-1:0] mem_wdata,
	input  rvlite_pkg::apb_rsp_t        bus_rsp,
	output rvlite_pkg::apb_req_t        bus_req,
	output logic                        mem_done,
	output logic [rvlite_pkg::xlen-1:0] mem_rdata,
	output logic                        mem_err
);

	typedef enum logic [1:0] {
		l_idle,
		l_setup,
		l_access
	} lsu_state_t;

	lsu_state_t                  state;
	logic [rvlite_pkg::xlen-1:0] addr_q;
	logic [rvlite_pkg::xlen-1:0] wdata_q;
	logic                        write_q;

	assign mem_done  = (state == l_access) && bus_rsp.pready;
	assign mem_rdata = bus_rsp.prdata;
	assign mem_err   = mem_done && bus_rsp.pslverr;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= l_idle;
		end else begin
			case (state)
				l_idle:   if (mem_req) state <= l_setup;
				l_setup:  state <= l_access;
				l_access: if (bus_rsp.pready) state <= l_idle;
				default:  state <= l_idle;
			endcase
		end
	end

	// request is captured once and held through the transfer
	always_ff @(posedge clk) begin
		if (state == l_idle) begin
			addr_q  <= mem_addr;
			wdata_q <= mem_wdata;
			write_q <= mem_write;
		end
	end

	always_comb begin
		bus_req.paddr   = addr_q;
		bus_req.pwdata  = wdata_q;
		bus_req.pwrite  = write_q;
		bus_req.psel    = (state != l_idle);
		bus_req.penable = (state == l_access);
	end

endmodule

//--- logic/rvlite_mem_arbiter.sv
// fixed priority to the load/store unit and the arbiter makes its own setup phase to the slave
module rvlite_mem_arbiter (
	input  logic                 clk,
	input  logic                 rst,
	input  rvlite_pkg::apb_req_t ifu_req,
	input  rvlite_pkg::apb_req_t lsu_req,
	input  rvlite_pkg::apb_rsp_t slv_rsp,
	output rvlite_pkg::apb_rsp_t ifu_rsp,
	output rvlite_pkg::apb_rsp_t lsu_rsp,
	output rvlite_pkg::apb_req_t slv_req
);

	// busy marks the access phase of a granted transfer
	logic                 busy;
	logic                 owner_lsu;
	logic                 grant_lsu;
	rvlite_pkg::apb_req_t sel_req;

	// owner is locked while busy, otherwise lsu wins any tie
	assign grant_lsu = busy ? owner_lsu : lsu_req.psel;
	assign sel_req   = grant_lsu ? lsu_req : ifu_req;

	always_comb begin
		slv_req         = sel_req;
		slv_req.psel    = busy || sel_req.psel;
		slv_req.penable = busy;
	end

	// the master that does not own the bus just sees a long wait
	always_comb begin
		ifu_rsp         = slv_rsp;
		lsu_rsp         = slv_rsp;
		ifu_rsp.pready  = busy && !owner_lsu && slv_rsp.pready;
		ifu_rsp.pslverr = busy && !owner_lsu && slv_rsp.pslverr;
		lsu_rsp.pready  = busy && owner_lsu && slv_rsp.pready;
		lsu_rsp.pslverr = busy && owner_lsu && slv_rsp.pslverr;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			busy      <= 1'b0;
			owner_lsu <= 1'b0;
		end else if (!busy) begin
			if (sel_req.psel) begin
				busy      <= 1'b1;
				owner_lsu <= grant_lsu;
			end
		end else if (slv_rsp.pready) begin
			busy <= 1'b0;
		end
	end

endmodule

//--- logic/rvlite_top.sv
// one apb master port shared by fetch and data with the retire trace one cycle after commit
module rvlite_top (
	input  logic                 clk,
	input  logic                 rst,
	input  rvlite_pkg::apb_rsp_t apb_rsp,
	output rvlite_pkg::apb_req_t apb_req,
	output rvlite_pkg::retire_t  retire,
	output logic                 halted
);

	logic                              commit;
	logic [rvlite_pkg::xlen-1:0]       next_pc;
	logic                              inst_valid;
	logic                              inst_ready;
	rvlite_pkg::inst_word_u            inst;
	logic [rvlite_pkg::xlen-1:0]       inst_pc;
	rvlite_pkg::decode_t               dec;
	logic [rvlite_pkg::reg_addr_w-1:0] wb_addr;
	logic [rvlite_pkg::xlen-1:0]       wb_data;
	logic                              wb_en;
	logic                              mem_req;
	logic                              mem_write;
	logic [rvlite_pkg::xlen-1:0]       mem_addr;
	logic [rvlite_pkg::xlen-1:0]       mem_wdata;
	logic                              mem_done;
	logic [rvlite_pkg::xlen-1:0]       mem_rdata;
	logic                              mem_err;
	rvlite_pkg::apb_req_t              ifu_req;
	rvlite_pkg::apb_rsp_t              ifu_rsp;
	rvlite_pkg::apb_req_t              lsu_req;
	rvlite_pkg::apb_rsp_t              lsu_rsp;

	rvlite_ifu rvlite_ifu_i (
		.clk        (clk),
		.rst        (rst),
		.commit     (commit),
		.next_pc    (next_pc),
		.halted     (halted),
		.inst_ready (inst_ready),
		.bus_rsp    (ifu_rsp),
		.bus_req    (ifu_req),
		.inst_valid (inst_valid),
		.inst       (inst),
		.inst_pc    (inst_pc)
	);

	rvlite_idu rvlite_idu_i (
		.clk     (clk),
		.inst    (inst),
		.inst_pc (inst_pc),
		.wb_addr (wb_addr),
		.wb_data (wb_data),
		.wb_en   (wb_en),
		.dec     (dec)
	);

	rvlite_exu rvlite_exu_i (
		.clk        (clk),
		.rst        (rst),
		.dec        (dec),
		.inst_valid (inst_valid),
		.mem_done   (mem_done),
		.mem_rdata  (mem_rdata),
		.mem_err    (mem_err),
		.inst_ready (inst_ready),
		.mem_req    (mem_req),
		.mem_write  (mem_write),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata),
		.wb_addr    (wb_addr),
		.wb_data    (wb_data),
		.wb_en      (wb_en),
		.commit     (commit),
		.next_pc    (next_pc),
		.halted     (halted),
		.retire     (retire)
	);

	rvlite_lsu rvlite_lsu_i (
		.clk       (clk),
		.rst       (rst),
		.mem_req   (mem_req),
		.mem_write (mem_write),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.bus_rsp   (lsu_rsp),
		.bus_req   (lsu_req),
		.mem_done  (mem_done),
		.mem_rdata (mem_rdata),
		.mem_err   (mem_err)
	);

	rvlite_mem_arbiter rvlite_mem_arbiter_i (
		.clk     (clk),
		.rst     (rst),
		.ifu_req (ifu_req),
		.lsu_req (lsu_req),
		.slv_rsp (apb_rsp),
		.ifu_rsp (ifu_rsp),
		.lsu_rsp (lsu_rsp),
		.slv_req (apb_req)
	);

endmodule

//--- dv/rvlite_assertions.sv
// checks the slave side of the arbiter for masters that hold psel until pready, with a synchronous active high rst
module rvlite_assertions (
	input logic                 clk,
	input logic                 rst,
	input rvlite_pkg::apb_req_t ifu_req,
	input rvlite_pkg::apb_req_t lsu_req,
	input rvlite_pkg::apb_req_t slv_req,
	input rvlite_pkg::apb_rsp_t slv_rsp,
	input logic                 busy,
	input logic                 owner_lsu
);

	timeunit 1ns;
	timeprecision 100ps;

	// setup is followed by access with the same request
	setup_then_access: assert property (@(posedge clk) disable iff (rst)
		(slv_req.psel && !slv_req.penable) |=>
		(slv_req.psel && slv_req.penable && $stable(slv_req.paddr) &&
		$stable(slv_req.pwrite) && $stable(slv_req.pwdata)))
		else $error("apb access phase did not follow setup with a stable request");

	// slave wait states
	hold_while_waiting: assert property (@(posedge clk) disable iff (rst)
		(slv_req.psel && slv_req.penable && !slv_rsp.pready) |=>
		(slv_req.psel && slv_req.penable && $stable(slv_req.paddr) &&
		$stable(slv_req.pwrite) && $stable(slv_req.pwdata)))
		else $error("apb request changed while pready was low");

	// the owner is a master that is still in its own access phase
	owner_locked: assert property (@(posedge clk) disable iff (rst)
		busy |-> (owner_lsu ? (lsu_req.psel && lsu_req.penable) :
		(ifu_req.psel && ifu_req.penable)))
		else $error("arbiter grant moved away from the master in its transfer");

endmodule

bind rvlite_mem_arbiter rvlite_assertions rvlite_assertions_i (
	.clk       (clk),
	.rst       (rst),
	.ifu_req   (ifu_req),
	.lsu_req   (lsu_req),
	.slv_req   (slv_req),
	.slv_rsp   (slv_rsp),
	.busy      (busy),
	.owner_lsu (owner_lsu)
);

//--- dv/rvlite_checker.sv
// samples the dut at the rising edge and holds at most 8 retires and 4 memory writes per test
module rvlite_checker (
	input  logic                 clk,
	input  logic                 rst,
	input  rvlite_pkg::retire_t  retire,
	input  logic                 halted,
	input  rvlite_pkg::apb_req_t apb_req,
	input  rvlite_pkg::apb_rsp_t apb_rsp,
	input  logic [7:0][31:0]     exp_pc,
	input  logic [7:0][4:0]      exp_rd,
	input  logic [7:0][31:0]     exp_wdata,
	input  logic [7:0]           exp_wen,
	input  logic [3:0]           n_ret,
	input  logic [3:0][31:0]     wr_addr,
	input  logic [3:0][31:0]     wr_data,
	input  logic [2:0]           n_wr,
	input  logic                 err_halt,
	input  int                   test_idx,
	input  logic                 check_end,
	input  logic                 summary,
	output int                   passed,
	output int                   failed
);

	timeunit 1ns;
	timeprecision 100ps;

	int   ret_cnt;
	int   wr_cnt;
	int   errs;
	logic halt_seen;
	logic err_seen;

	task automatic compare_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("Fail test %0d %s: got 0x%08h expected 0x%08h", test_idx, what, got, exp);
			errs++;
		end
	endtask

	task automatic complain(input string msg);
		$display("test %0d: %s", test_idx, msg);
		errs++;
	endtask

	initial begin
		passed = 0;
		failed = 0;
	end

	always @(posedge clk) begin
		if (rst) begin
			ret_cnt   = 0;
			wr_cnt    = 0;
			errs      = 0;
			halt_seen = 1'b0;
			err_seen  = 1'b0;
		end else begin
			if (retire.valid) begin
				if (halt_seen)
					complain($sformatf("retire at pc 0x%08h after the core halted", retire.pc));
				else if (ret_cnt >= n_ret)
					complain($sformatf("unexpected extra retire at pc 0x%08h", retire.pc));
				else begin
					compare_value($sformatf("retire.pc[%0d]", ret_cnt), retire.pc, exp_pc[ret_cnt]);
					compare_value($sformatf("retire.wen[%0d]", ret_cnt), retire.wen,
						exp_wen[ret_cnt]);
					// rd and wdata only mean something when a register is written
					if (exp_wen[ret_cnt]) begin
						compare_value($sformatf("retire.rd[%0d]", ret_cnt), retire.rd,
							exp_rd[ret_cnt]);
						compare_value($sformatf("retire.wdata[%0d]", ret_cnt), retire.wdata,
							exp_wdata[ret_cnt]);
					end
				end
				ret_cnt++;
			end
			if (apb_req.psel && apb_req.penable && apb_rsp.pready) begin
				if (apb_rsp.pslverr)
					err_seen = 1'b1;
				else if (apb_req.pwrite) begin
					if (wr_cnt >= n_wr)
						complain($sformatf("unexpected memory write to 0x%08h", apb_req.paddr));
					else begin
						compare_value("paddr", apb_req.paddr, wr_addr[wr_cnt]);
						compare_value("pwdata", apb_req.pwdata, wr_data[wr_cnt]);
					end
					wr_cnt++;
				end
			end
			if (halted && apb_req.psel && !apb_req.penable)
				complain("an apb transfer started after the core halted");
			if (halted && !halt_seen) begin
				halt_seen = 1'b1;
				if (ret_cnt != n_ret)
					complain($sformatf("halted after %0d of %0d retires", ret_cnt, n_ret));
			end
			if (check_end) begin
				if (ret_cnt < n_ret)
					complain($sformatf("missing retire, only %0d of %0d seen", ret_cnt, n_ret));
				if (wr_cnt < n_wr)
					complain($sformatf("missing memory write, only %0d of %0d seen", wr_cnt, n_wr));
				if (err_seen != err_halt)
					complain("bus error response did not match the expected halt cause");
				if (errs == 0) begin
					$display("test %0d passed", test_idx);
					passed++;
				end else begin
					$display("test %0d failed with %0d errors", test_idx, errs);
					failed++;
				end
			end
			if (summary)
				$display("tests passed: %0d, tests failed: %0d", passed, failed);
		end
	end

endmodule

//--- dv/rvlite_tb.sv
// memory model decodes word addresses below 4 KiB and answers pslverr at and above err_base
module rvlite_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int          num_tests = 4;
	localparam logic [31:0] err_base  = 32'h0001_0000;
	localparam logic [31:0] ebreak_w  = 32'h0010_0073;

	typedef struct packed {
		logic [7:0][31:0] prog;
		logic [3:0]       n_prog;
		logic [7:0][31:0] ret_pc;
		logic [7:0][4:0]  ret_rd;
		logic [7:0][31:0] ret_wdata;
		logic [7:0]       ret_wen;
		logic [3:0]       n_ret;
		logic [3:0][31:0] wr_addr;
		logic [3:0][31:0] wr_data;
		logic [2:0]       n_wr;
		logic             err_halt;
	} test_row_t;

	logic                 clk;
	logic                 rst;
	rvlite_pkg::apb_req_t apb_req;
	rvlite_pkg::apb_rsp_t apb_rsp;
	rvlite_pkg::retire_t  retire;
	logic                 halted;
	test_row_t            tests [num_tests];
	test_row_t            cur;
	int                   test_idx;
	logic                 check_end;
	logic                 summary;
	int                   passed;
	int                   failed;
	logic [31:0]          mem [1024];
	int                   seed;
	int                   wait_left;
	int                   cycles;
	int                   limit;

	rvlite_top rvlite_top_i (
		.clk     (clk),
		.rst     (rst),
		.apb_rsp (apb_rsp),
		.apb_req (apb_req),
		.retire  (retire),
		.halted  (halted)
	);

	rvlite_checker rvlite_checker_i (
		.clk       (clk),
		.rst       (rst),
		.retire    (retire),
		.halted    (halted),
		.apb_req   (apb_req),
		.apb_rsp   (apb_rsp),
		.exp_pc    (cur.ret_pc),
		.exp_rd    (cur.ret_rd),
		.exp_wdata (cur.ret_wdata),
		.exp_wen   (cur.ret_wen),
		.n_ret     (cur.n_ret),
		.wr_addr   (cur.wr_addr),
		.wr_data   (cur.wr_data),
		.n_wr      (cur.n_wr),
		.err_halt  (cur.err_halt),
		.test_idx  (test_idx),
		.check_end (check_end),
		.summary   (summary),
		.passed    (passed),
		.failed    (failed)
	);

	always #20 clk = ~clk;

	// instruction encoders
	function automatic logic [31:0] addi_word(input logic [4:0] rd, input logic [4:0] rs1,
		input logic [11:0] imm);
		return {imm, rs1, 3'b000, rd, rvlite_pkg::opc_op_imm};
	endfunction

	function automatic logic [31:0] upper_word(input logic [6:0] opc, input logic [4:0] rd,
		input logic [19:0] imm);
		return {imm, rd, opc};
	endfunction

	function automatic logic [31:0] jal_word(input logic [4:0] rd, input logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, rvlite_pkg::opc_jal};
	endfunction

	function automatic logic [31:0] jalr_word(input logic [4:0] rd, input logic [4:0] rs1,
		input logic [11:0] imm);
		return {imm, rs1, 3'b000, rd, rvlite_pkg::opc_jalr};
	endfunction

	function automatic logic [31:0] lw_word(input logic [4:0] rd, input logic [4:0] rs1,
		input logic [11:0] imm);
		return {imm, rs1, 3'b010, rd, rvlite_pkg::opc_load};
	endfunction

	function automatic logic [31:0] sw_word(input logic [4:0] rs2, input logic [4:0] rs1,
		input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rvlite_pkg::opc_store};
	endfunction

	task automatic add_word(input int t, input logic [31:0] w);
		tests[t].prog[tests[t].n_prog] = w;
		tests[t].n_prog++;
	endtask

	task automatic expect_retire(input int t, input logic [31:0] pc, input logic [4:0] rd,
		input logic [31:0] wdata, input logic wen);
		tests[t].ret_pc[tests[t].n_ret]    = pc;
		tests[t].ret_rd[tests[t].n_ret]    = rd;
		tests[t].ret_wdata[tests[t].n_ret] = wdata;
		tests[t].ret_wen[tests[t].n_ret]   = wen;
		tests[t].n_ret++;
	endtask

	task automatic expect_write(input int t, input logic [31:0] addr, input logic [31:0] data);
		tests[t].wr_addr[tests[t].n_wr] = addr;
		tests[t].wr_data[tests[t].n_wr] = data;
		tests[t].n_wr++;
	endtask

	task automatic build_table();
		for (int t = 0; t < num_tests; t++)
			tests[t] = '0;
		// arithmetic, x0 write and ebreak
		add_word(0, addi_word(1, 0, 12'd100));
		add_word(0, addi_word(2, 1, -12'sd3));
		add_word(0, upper_word(rvlite_pkg::opc_lui, 3, 20'h12345));
		add_word(0, upper_word(rvlite_pkg::opc_auipc, 4, 20'h00001));
		add_word(0, addi_word(0, 0, 12'd5));
		add_word(0, addi_word(5, 0, 12'hfff));
		add_word(0, ebreak_w);
		expect_retire(0, 32'h00, 1, 32'd100, 1'b1);
		expect_retire(0, 32'h04, 2, 32'd97, 1'b1);
		expect_retire(0, 32'h08, 3, 32'h1234_5000, 1'b1);
		expect_retire(0, 32'h0c, 4, 32'h0000_100c, 1'b1);
		expect_retire(0, 32'h10, 0, 32'h0, 1'b1);
		expect_retire(0, 32'h14, 5, 32'hffff_ffff, 1'b1);
		expect_retire(0, 32'h18, 0, 32'h0, 1'b0);
		// jal over two words, then jalr to an odd target
		add_word(1, jal_word(1, 21'd12));
		add_word(1, addi_word(6, 0, 12'd1));
		add_word(1, addi_word(6, 0, 12'd2));
		add_word(1, addi_word(2, 0, 12'h019));
		add_word(1, jalr_word(3, 2, 12'd0));
		add_word(1, addi_word(7, 0, 12'd3));
		add_word(1, addi_word(4, 1, 12'd1));
		add_word(1, ebreak_w);
		expect_retire(1, 32'h00, 1, 32'h04, 1'b1);
		expect_retire(1, 32'h0c, 2, 32'h19, 1'b1);
		expect_retire(1, 32'h10, 3, 32'h14, 1'b1);
		expect_retire(1, 32'h18, 4, 32'h05, 1'b1);
		expect_retire(1, 32'h1c, 0, 32'h0, 1'b0);
		// stores then loads of the same words
		add_word(2, addi_word(1, 0, 12'h200));
		add_word(2, addi_word(2, 0, 12'h5a5));
		add_word(2, sw_word(2, 1, 12'd8));
		add_word(2, upper_word(rvlite_pkg::opc_lui, 3, 20'habcde));
		add_word(2, sw_word(3, 1, -12'sd4));
		add_word(2, lw_word(4, 1, 12'd8));
		add_word(2, lw_word(5, 1, -12'sd4));
		add_word(2, ebreak_w);
		expect_retire(2, 32'h00, 1, 32'h200, 1'b1);
		expect_retire(2, 32'h04, 2, 32'h5a5, 1'b1);
		expect_retire(2, 32'h08, 0, 32'h0, 1'b0);
		expect_retire(2, 32'h0c, 3, 32'habcd_e000, 1'b1);
		expect_retire(2, 32'h10, 0, 32'h0, 1'b0);
		expect_retire(2, 32'h14, 4, 32'h5a5, 1'b1);
		expect_retire(2, 32'h18, 5, 32'habcd_e000, 1'b1);
		expect_retire(2, 32'h1c, 0, 32'h0, 1'b0);
		expect_write(2, 32'h208, 32'h5a5);
		expect_write(2, 32'h1fc, 32'habcd_e000);
		// unsupported add and beq, then a store into the error range
		add_word(3, upper_word(rvlite_pkg::opc_lui, 1, 20'h00010));
		add_word(3, 32'h0020_81b3);
		add_word(3, 32'h0000_0063);
		add_word(3, addi_word(2, 0, 12'h077));
		add_word(3, sw_word(2, 1, 12'd4));
		add_word(3, addi_word(5, 0, 12'd1));
		add_word(3, ebreak_w);
		expect_retire(3, 32'h00, 1, 32'h0001_0000, 1'b1);
		expect_retire(3, 32'h04, 0, 32'h0, 1'b0);
		expect_retire(3, 32'h08, 0, 32'h0, 1'b0);
		expect_retire(3, 32'h0c, 2, 32'h77, 1'b1);
		tests[3].err_halt = 1'b1;
	endtask

	// unused words carry their own address
	task automatic load_memory(input test_row_t row);
		for (int i = 0; i < 1024; i++)
			mem[i] = 32'h0bad_0000 | (i << 2);
		for (int i = 0; i < row.n_prog; i++)
			mem[i] = row.prog[i];
	endtask

	// apb slave with 0 to 3 wait states per transfer
	always @(negedge clk) begin
		apb_rsp <= '0;
		if (!rst && apb_req.psel) begin
			if (!apb_req.penable)
				wait_left = $unsigned($random(seed)) % 4;
			else if (wait_left > 0)
				wait_left--;
			else begin
				apb_rsp.pready <= 1'b1;
				if (apb_req.paddr >= err_base)
					apb_rsp.pslverr <= 1'b1;
				else if (apb_req.pwrite)
					mem[apb_req.paddr[11:2]] = apb_req.pwdata;
				else
					apb_rsp.prdata <= mem[apb_req.paddr[11:2]];
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > limit) begin
			$display("timeout in test %0d: halted did not rise within %0d cycles", test_idx, limit);
			$display("Regression failed");
			$finish;
		end
	end

	initial begin
		clk       = 1'b0;
		rst       = 1'b1;
		apb_rsp   = '0;
		seed      = 29;
		wait_left = 0;
		cycles    = 0;
		test_idx  = 0;
		check_end = 1'b0;
		summary   = 1'b0;
		build_table();
		cur   = tests[0];
		limit = 50 * num_tests;
		for (int t = 0; t < num_tests; t++)
			limit += 20 * tests[t].n_prog;
		for (int t = 0; t < num_tests; t++) begin
			@(negedge clk);
			rst      = 1'b1;
			cur      = tests[t];
			test_idx = t;
			load_memory(tests[t]);
			repeat (3) @(negedge clk);
			rst = 1'b0;
			while (!halted)
				@(negedge clk);
			// quiet window after the halt
			repeat (10) @(negedge clk);
			check_end = 1'b1;
			@(negedge clk);
			check_end = 1'b0;
		end
		summary = 1'b1;
		@(negedge clk);
		summary = 1'b0;
		if (failed == 0 && passed == num_tests)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

//--- rvlite.f
logic/rvlite_pkg.sv
logic/rvlite_regfile.sv
logic/rvlite_ifu.sv
logic/rvlite_idu.sv
logic/rvlite_exu.sv
logic/rvlite_lsu.sv
logic/rvlite_mem_arbiter.sv
logic/rvlite_top.sv
dv/rvlite_assertions.sv
dv/rvlite_checker.sv
dv/rvlite_tb.sv
